//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dataMmuTb
FILELIST  = dataMmu.f
PASS_MSG  = All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- dataMmu.f
+incdir+dv
hdl/mmuPkg.sv
hdl/tlbArray.sv
hdl/tlbBuffer.sv
hdl/refillControl.sv
hdl/accessCheck.sv
hdl/dataMmu.sv
dv/dataMmuTb.sv

//--- dv/dataMmuPatterns.txt
# W slot vpn2 asid g0 g1 pfn0 attr0 d0 v0 pfn1 attr1 d1 v1 | P vpn2 asid expFound expIndex
# A vaddr L|S asid expPaddr expCached expValid expExc(rdRef rdInv wrRef wrInv mod) expStall
A 80001234 L 01 00001234 1 1 00000 0
A 9ffffffc S 01 1ffffffc 1 1 00000 0
A a0000010 L 01 00000010 0 1 00000 0
A bffff000 S 01 1ffff000 0 1 00000 0
W 3 00010 01 0 0 12345 3 1 1 0abcd 2 1 1
A 00020abc L 01 12345abc 1 1 00000 2
A 00021ff0 L 01 0abcdff0 0 1 00000 0
A 00020008 S 01 12345008 1 1 00000 0
A 00060100 L 01 00000100 0 0 10000 2
A 00060200 S 01 00000200 0 0 00100 0
A 00020010 L 22 00000010 0 0 10000 2
A 00020020 S 22 00000020 0 0 00100 0
W 4 00040 55 1 1 44444 3 1 1 55555 0 1 1
A 00080010 L 01 44444010 1 1 00000 2
A 00081010 S 01 55555010 0 1 00000 0
W 5 00050 55 1 0 66666 3 1 1 66666 3 1 1
A 000a0010 L 01 00000010 0 0 10000 2
W 6 60000 01 0 0 22222 3 0 1 33333 3 1 0
A c0001040 L 01 33333040 1 0 01000 2
A c0001044 S 01 33333044 1 0 00010 0
A c0000100 S 01 22222100 1 0 00001 0
A c0000104 L 01 22222104 1 1 00000 0
P 00010 01 1 3
P 60000 01 1 6
P 00040 99 1 4
P 00050 01 0 0
P 00070 01 0 0
W 9 00070 01 0 0 77777 3 1 1 77777 3 1 1
W 1 00070 01 0 0 78787 3 1 1 78787 3 1 1
P 00070 01 1 1
A 00020abc L 01 12345abc 1 1 00000 2
W 3 00010 01 0 0 45678 3 1 1 0abcd 2 1 1
A 00020abc L 01 45678abc 1 1 00000 2
A 00020abd L 01 45678abd 1 1 00000 0
P 00010 01 1 3

//--- dv/dataMmuChecks.svh
// typed compare tasks and error counters for the data MMU testbench, included in its top module
`ifndef DATA_MMU_CHECKS_SVH
`define DATA_MMU_CHECKS_SVH

int mismatchCount = 0;
int otherErrorCount = 0;

// failures that are not a wrong value
task automatic reportError(input string what);
    otherErrorCount++;
    $display("Error: %s", what);
endtask

task automatic checkPaddr(input string testName, input paddrT expected, input paddrT actual);
    if (actual !== expected) begin
        mismatchCount++;
        $display("Mismatch %s: expected %h, actual %h", testName, expected, actual);
    end
endtask

// cached, accessValid and probeFound
task automatic checkBit(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
        mismatchCount++;
        $display("Mismatch %s: expected %b, actual %b", testName, expected, actual);
    end
endtask

task automatic checkIndex(input string testName, input tlbIndexT expected, input tlbIndexT actual);
    if (actual !== expected) begin
        mismatchCount++;
        $display("Mismatch %s: expected %0d, actual %0d", testName, expected, actual);
    end
endtask

// flags in the order rdRefill rdInvalid wrRefill wrInvalid modified
task automatic checkExc(input string testName, input tlbExcT expected, input tlbExcT actual);
    if (actual !== expected) begin
        mismatchCount++;
        $display("Mismatch %s: expected %b, actual %b", testName, expected, actual);
    end
endtask

task automatic checkCount(input string testName, input int expected, input int actual);
    if (actual != expected) begin
        mismatchCount++;
        $display("Mismatch %s: expected %0d, actual %0d", testName, expected, actual);
    end
endtask

`endif

//--- dv/dataMmuTb.sv
// testbench for the data MMU, replays the pattern file of writes, probes and accesses against the DUT
`timescale 1ns/1ps
`default_nettype none

module dataMmuTb
    import mmuPkg::*;
();

    localparam int    HALF_PERIOD   = 50;
    localparam int    SETTLE        = 10;   // sample point after the falling edge
    localparam int    STALL_TIMEOUT = 10;
    localparam int    MAX_LINES     = 1000;
    localparam string PATTERN_FILE  = "dv/dataMmuPatterns.txt";

    logic       clk;
    logic       rstN;
    memReqT     req;
    cp0TlbRegsT cp0Regs;
    tlbIndexT   cp0Index;
    logic       tlbWrite;
    logic       tlbProbe;
    paddrT      paddr;
    logic       cached;
    logic       accessValid;
    logic       tlbStall;
    tlbExcT     exc;
    logic       probeFound;
    tlbIndexT   probeIndex;

    `include "dataMmuChecks.svh"

    dataMmu #(
        .tlbEntries(16)
    ) dut (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .cp0Regs    (cp0Regs),
        .cp0Index   (cp0Index),
        .tlbWrite   (tlbWrite),
        .tlbProbe   (tlbProbe),
        .paddr      (paddr),
        .cached     (cached),
        .accessValid(accessValid),
        .tlbStall   (tlbStall),
        .exc        (exc),
        .probeFound (probeFound),
        .probeIndex (probeIndex)
    );

    always #HALF_PERIOD clk = ~clk;

    // W slot vpn2 asid g0 g1 pfn0 attr0 d0 v0 pfn1 attr1 d1 v1
    task automatic runWrite(input string line, input int lineNo);
        byte         op;
        logic [31:0] slot, vpn2, asid, g0, g1;
        logic [31:0] pfn0, attr0, dirty0, valid0, pfn1, attr1, dirty1, valid1;
        int          n;
        n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h", op, slot, vpn2,
                    asid, g0, g1, pfn0, attr0, dirty0, valid0, pfn1, attr1, dirty1, valid1);
        if (n != 14) begin
            reportError($sformatf("line %0d: malformed write line", lineNo));
        end else begin
            @(negedge clk);
            cp0Index        = tlbIndexT'(slot);
            cp0Regs.vpn2    = vpn2T'(vpn2);
            cp0Regs.asid    = asidT'(asid);
            cp0Regs.global0 = g0[0];
            cp0Regs.global1 = g1[0];
            cp0Regs.lo0     = {pfnT'(pfn0), cacheAttrT'(attr0), dirty0[0], valid0[0]};
            cp0Regs.lo1     = {pfnT'(pfn1), cacheAttrT'(attr1), dirty1[0], valid1[0]};
            tlbWrite        = 1'b1;
            @(negedge clk);
            tlbWrite        = 1'b0;   // one-cycle strobe
        end
    endtask

    // P vpn2 asid expFound expIndex
    task automatic runProbe(input string line, input int lineNo);
        byte         op;
        logic [31:0] vpn2, asid, expFound, expIndex;
        int          n;
        string       name;
        name = $sformatf("line %0d", lineNo);
        n = $sscanf(line, "%c %h %h %h %h", op, vpn2, asid, expFound, expIndex);
        if (n != 5) begin
            reportError($sformatf("%s: malformed probe line", name));
        end else begin
            @(negedge clk);
            req          = '0;        // no access while probing
            cp0Regs.vpn2 = vpn2T'(vpn2);
            cp0Regs.asid = asidT'(asid);
            tlbProbe     = 1'b1;
            #SETTLE;
            checkBit({name, " probeFound"}, expFound[0], probeFound);
            if (expFound[0]) begin
                checkIndex({name, " probeIndex"}, tlbIndexT'(expIndex), probeIndex);
            end
            @(negedge clk);
            tlbProbe = 1'b0;
        end
    endtask

    // A vaddr L|S asid expPaddr expCached expValid expExc expStall
    task automatic runAccess(input string line, input int lineNo);
        byte         op;
        byte         kind;
        logic [31:0] vaddr, asid, expPaddr, expCached, expValid, expExc, expStall;
        int          n;
        int          stallCycles;
        string       name;
        name = $sformatf("line %0d", lineNo);
        n = $sscanf(line, "%c %h %c %h %h %h %h %b %d", op, vaddr, kind, asid,
                    expPaddr, expCached, expValid, expExc, expStall);
        if (n != 9 || (kind != "L" && kind != "S")) begin
            reportError($sformatf("%s: malformed access line", name));
        end else begin
            @(negedge clk);
            req.vaddr    = vaddrT'(vaddr);
            req.load     = (kind == "L");
            req.store    = (kind == "S");
            cp0Regs.asid = asidT'(asid);
            #SETTLE;
            stallCycles = 0;
            while (tlbStall && stallCycles < STALL_TIMEOUT) begin
                stallCycles++;
                @(negedge clk);
                #SETTLE;
            end
            if (tlbStall) begin
                reportError($sformatf("%s: stall did not end within %0d cycles", name,
                                      STALL_TIMEOUT));
            end else begin
                checkCount({name, " stall cycles"}, int'(expStall), stallCycles);
                checkPaddr({name, " paddr"}, paddrT'(expPaddr), paddr);
                checkBit({name, " cached"}, expCached[0], cached);
                checkBit({name, " accessValid"}, expValid[0], accessValid);
                checkExc({name, " exc"}, tlbExcT'(expExc[4:0]), exc);
            end
            @(negedge clk);
            req = '0;
        end
    endtask

    initial begin
        int    fd;
        int    lineNo;
        int    opCount;
        string line;
        byte   op;
        clk      = 1'b0;
        rstN     = 1'b0;
        req      = '0;
        cp0Regs  = '0;
        cp0Index = '0;
        tlbWrite = 1'b0;
        tlbProbe = 1'b0;
        lineNo   = 0;
        opCount  = 0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            reportError({"cannot open ", PATTERN_FILE});
        end else begin
            while (!$feof(fd) && lineNo < MAX_LINES) begin
                line = "";
                void'($fgets(line, fd));
                lineNo++;
                if (line.len() > 0) begin
                    op = line.getc(0);
                    case (op)
                        "W": runWrite(line, lineNo);
                        "P": runProbe(line, lineNo);
                        "A": runAccess(line, lineNo);
                        "#", "\n", "\r", " ": ;   // comments and blank lines
                        default: reportError($sformatf("line %0d: unknown operation", lineNo));
                    endcase
                    if (op == "W" || op == "P" || op == "A") begin
                        opCount++;
                    end
                end
            end
            $fclose(fd);
        end
        if (opCount == 0) begin
            reportError("no operations were read from the pattern file");
        end
        $display("%0d operations, %0d mismatches, %0d other errors", opCount, mismatchCount,
                 otherErrorCount);
        if (mismatchCount == 0 && otherErrorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/accessCheck.sv
// combinational segment decode, physical address, cache attribute and TLB exception check
`timescale 1ns/1ps
`default_nettype none

module accessCheck
    import mmuPkg::*;
(
    input  memReqT   req,
    input  asidT     curAsid,
    input  tlbEntryT bufEntry,
    input  logic     bufInTlb,
    input  logic     tlbStall,
    output logic     needLookup,
    output paddrT    paddr,
    output logic     cached,
    output logic     accessValid,
    output tlbExcT   exc
);

    logic   access;
    logic   inKseg0;
    logic   inKseg1;
    logic   mapped;
    logic   noEntry;
    pageLoT page;

    assign access = req.load | req.store;

    // unmapped kernel windows
    assign inKseg0 = (req.vaddr >= KSEG0_BASE) && (req.vaddr < KSEG1_BASE);
    assign inKseg1 = (req.vaddr >= KSEG1_BASE) && (req.vaddr < KSEG2_BASE);
    assign mapped  = !(inKseg0 || inKseg1);

    assign needLookup = access && mapped;

    // even or odd half of the pair
    assign page = req.vaddr[12] ? bufEntry.odd : bufEntry.even;

    // refill when nothing was found or the entry belongs to another space
    assign noEntry = !bufInTlb ||
                     ((bufEntry.asid != curAsid) && !bufEntry.isGlobal);

    always_comb begin
        if (inKseg0) begin
            paddr  = req.vaddr - KSEG0_BASE;
            cached = 1'b1;
        end else if (inKseg1) begin
            paddr  = req.vaddr - KSEG1_BASE;
            cached = 1'b0;
        end else begin
            paddr  = {page.pfn, req.vaddr[11:0]};
            cached = (page.cacheAttr == CACHE_CACHEABLE);
        end
    end

    // first matching rule wins
    always_comb begin
        exc         = '0;
        accessValid = 1'b0;
        if (!access || tlbStall) begin
            accessValid = 1'b0;           // nothing to report yet
        end else if (!mapped) begin
            accessValid = 1'b1;
        end else if (noEntry) begin
            exc.rdRefill = req.load;
            exc.wrRefill = req.store;
        end else if (!page.valid) begin
            exc.rdInvalid = req.load;
            exc.wrInvalid = req.store;
        end else if (req.store && !page.dirty) begin
            exc.modified = 1'b1;          // store to a clean page
        end else begin
            accessValid = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dataMmu.sv
// top level of the data-side address translator, connecting TLB, buffer, FSM and access check
`timescale 1ns/1ps
`default_nettype none

module dataMmu
    import mmuPkg::*;
#(
    parameter int tlbEntries = 16
) (
    input  logic       clk,
    input  logic       rstN,
    input  memReqT     req,
    input  cp0TlbRegsT cp0Regs,
    input  tlbIndexT   cp0Index,
    input  logic       tlbWrite,     // TLBWI strobe
    input  logic       tlbProbe,     // TLBP level
    output paddrT      paddr,
    output logic       cached,
    output logic       accessValid,
    output logic       tlbStall,
    output tlbExcT     exc,
    output logic       probeFound,
    output tlbIndexT   probeIndex
);

    vpn2T     searchVpn2;
    logic     searchFound;
    tlbIndexT searchIndex;
    tlbEntryT searchEntry;
    logic     needLookup;
    logic     bufMatch;
    logic     bufWrite;
    tlbEntryT bufEntry;
    logic     bufInTlb;

    tlbArray #(
        .tlbEntries(tlbEntries)
    ) uTlbArray (
        .clk        (clk),
        .rstN       (rstN),
        .write      (tlbWrite),
        .writeIndex (cp0Index),
        .writeRegs  (cp0Regs),
        .searchVpn2 (searchVpn2),
        .searchAsid (cp0Regs.asid),
        .searchFound(searchFound),
        .searchIndex(searchIndex),
        .searchEntry(searchEntry)
    );

    // a TLB write is the only flush source
    tlbBuffer uTlbBuffer (
        .clk     (clk),
        .rstN    (rstN),
        .load    (bufWrite),
        .clear   (tlbWrite),
        .vpn2    (req.vaddr[31:13]),
        .entry   (searchEntry),
        .found   (searchFound),
        .match   (bufMatch),
        .bufEntry(bufEntry),
        .bufInTlb(bufInTlb)
    );

    refillControl uRefillControl (
        .clk       (clk),
        .rstN      (rstN),
        .needLookup(needLookup),
        .bufMatch  (bufMatch),
        .probe     (tlbProbe),
        .reqVpn2   (req.vaddr[31:13]),
        .probeVpn2 (cp0Regs.vpn2),
        .searchVpn2(searchVpn2),
        .bufWrite  (bufWrite),
        .tlbStall  (tlbStall)
    );

    accessCheck uAccessCheck (
        .req        (req),
        .curAsid    (cp0Regs.asid),
        .bufEntry   (bufEntry),
        .bufInTlb   (bufInTlb),
        .tlbStall   (tlbStall),
        .needLookup (needLookup),
        .paddr      (paddr),
        .cached     (cached),
        .accessValid(accessValid),
        .exc        (exc)
    );

    // probe results come straight off the search port
    assign probeFound = searchFound;
    assign probeIndex = searchIndex;

endmodule

`default_nettype wire

//--- hdl/mmuPkg.sv
// shared widths, segment constants and structs of the data MMU, imported by RTL and testbench
`default_nettype none

package mmuPkg;

    // address widths
    typedef logic [31:0] vaddrT;
    typedef logic [31:0] paddrT;

    // page pair number, top 19 bits of an address
    typedef logic [18:0] vpn2T;
    typedef logic [19:0] pfnT;
    typedef logic [7:0]  asidT;
    typedef logic [2:0]  cacheAttrT;

    localparam int TLB_INDEX_W = 4;
    typedef logic [TLB_INDEX_W-1:0] tlbIndexT;

    // only this attribute maps to a cached access
    localparam cacheAttrT CACHE_CACHEABLE = 3'd3;

    // segment boundaries
    localparam vaddrT KSEG0_BASE = 32'h8000_0000;
    localparam vaddrT KSEG1_BASE = 32'hA000_0000;
    localparam vaddrT KSEG2_BASE = 32'hC000_0000;

    // one half of a page pair, EntryLo layout
    typedef struct packed {
        pfnT       pfn;
        cacheAttrT cacheAttr;
        logic      dirty;     // page writable
        logic      valid;
    } pageLoT;

    // one TLB slot
    // the global flag is the AND of both EntryLo G bits
    typedef struct packed {
        vpn2T   vpn2;
        asidT   asid;
        logic   isGlobal;
        pageLoT even;         // selected by vaddr[12] == 0
        pageLoT odd;
    } tlbEntryT;

    // CP0 view used by TLBWI and TLBP
    typedef struct packed {
        vpn2T   vpn2;         // EntryHi
        asidT   asid;         // also the current address space
        logic   global0;
        logic   global1;
        pageLoT lo0;
        pageLoT lo1;
    } cp0TlbRegsT;

    // data access request, load and store exclusive
    typedef struct packed {
        vaddrT vaddr;
        logic  load;
        logic  store;
    } memReqT;

    // TLB exception flags
    typedef struct packed {
        logic rdRefill;
        logic rdInvalid;
        logic wrRefill;
        logic wrInvalid;
        logic modified;
    } tlbExcT;

endpackage

`default_nettype wire

//--- hdl/refillControl.sv
// idle/search FSM that stalls on a buffer miss, refills the buffer and picks the search key
`timescale 1ns/1ps
`default_nettype none

module refillControl
    import mmuPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic needLookup,    // mapped access present
    input  logic bufMatch,
    input  logic probe,         // TLBP in progress
    input  vpn2T reqVpn2,
    input  vpn2T probeVpn2,
    output vpn2T searchVpn2,
    output logic bufWrite,
    output logic tlbStall
);

    typedef enum logic {
        IDLE,
        SEARCH
    } stateT;

    stateT state;
    stateT nextState;
    logic  miss;

    assign miss = needLookup && !bufMatch;

    // miss in cycle N gives search in N+1, buffer loaded at its end
    always_comb begin
        if (miss) begin
            nextState = SEARCH;
        end else begin
            nextState = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign bufWrite = (state == SEARCH);
    assign tlbStall = miss;       // held until the buffer matches

    // probes share the data search port
    assign searchVpn2 = probe ? probeVpn2 : reqVpn2;

    // TLBP and a data access never share a cycle
    probeWithoutAccess: assert property (
        @(posedge clk) disable iff (!rstN)
        probe |-> !needLookup
    ) else $error("probe issued during a mapped access");

endmodule

`default_nettype wire

//--- hdl/tlbArray.sv
// TLB entry storage with an indexed write port and a combinational associative search port
`timescale 1ns/1ps
`default_nettype none

module tlbArray
    import mmuPkg::*;
#(
    parameter int tlbEntries = 16
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       write,
    input  tlbIndexT   writeIndex,
    input  cp0TlbRegsT writeRegs,
    input  vpn2T       searchVpn2,
    input  asidT       searchAsid,
    output logic       searchFound,
    output tlbIndexT   searchIndex,
    output tlbEntryT   searchEntry
);

    tlbEntryT               entries [tlbEntries];
    tlbEntryT               newEntry;
    logic [tlbEntries-1:0]  hit;

    // entry as TLBWI stores it
    always_comb begin
        newEntry.vpn2     = writeRegs.vpn2;
        newEntry.asid     = writeRegs.asid;
        newEntry.isGlobal = writeRegs.global0 & writeRegs.global1;
        newEntry.even     = writeRegs.lo0;
        newEntry.odd      = writeRegs.lo1;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < tlbEntries; i++) begin
                entries[i] <= '0;   // all pages invalid
            end
        end else if (write) begin
            entries[writeIndex] <= newEntry;
        end
    end

    // per-slot compare, asid ignored for global entries
    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            hit[i] = (entries[i].vpn2 == searchVpn2) &&
                     ((entries[i].asid == searchAsid) || entries[i].isGlobal);
        end
    end

    // walk downwards so the lowest matching slot wins
    always_comb begin
        searchFound = 1'b0;
        searchIndex = '0;
        searchEntry = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                searchFound = 1'b1;
                searchIndex = tlbIndexT'(i);
                searchEntry = entries[i];
            end
        end
    end

    // slots beyond tlbEntries do not exist
    writeIndexInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        write |-> (int'(writeIndex) < tlbEntries)
    ) else $error("TLB write index %0d out of range", writeIndex);

endmodule

`default_nettype wire

//--- hdl/tlbBuffer.sv
// one-entry translation buffer holding the last refilled page pair for the data port
`timescale 1ns/1ps
`default_nettype none

module tlbBuffer
    import mmuPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     load,       // refill from the search port
    input  logic     clear,      // TLB contents changed
    input  vpn2T     vpn2,
    input  tlbEntryT entry,
    input  logic     found,
    output logic     match,
    output tlbEntryT bufEntry,
    output logic     bufInTlb
);

    vpn2T     storedVpn2;
    tlbEntryT storedEntry;
    logic     storedInTlb;

    // clear wins over a load in the same cycle
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            storedVpn2  <= '0;
            storedEntry <= '0;
            storedInTlb <= 1'b0;
        end else if (load) begin
            storedVpn2  <= vpn2;      // request vpn2 is kept on a miss too
            storedEntry <= entry;
            storedInTlb <= found;     // only updated on a refill
        end
    end

    // the buffer answers for the vpn2 it was loaded with,
    // whether or not the TLB held an entry for it
    assign match = (storedVpn2 == vpn2);

    assign bufEntry = storedEntry;
    assign bufInTlb = storedInTlb;

endmodule

`default_nettype wire
